// File: tb.f
common/obj_pkg.sv
rtl/obj_zoom_calc.sv
rtl/obj_entry_sequencer.sv
rtl/obj_scroll_latch.sv
rtl/obj_placement.sv
rtl/obj_eval_top.sv
tests/obj_eval_assert.sv
tests/obj_eval_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= obj_eval_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/obj_eval_tb.sv
module obj_eval_tb;
    import obj_pkg::*;

    // each entry takes at most 40 cycles, plus room for reset and frame pulses
    localparam int ENTRY_COUNT    = 35;
    localparam int ENTRY_CYCLES   = 40;
    localparam int TIMEOUT_CYCLES = ENTRY_COUNT * ENTRY_CYCLES + 100;
    localparam int ENTRY_LATENCY  = 20;

    localparam logic [15:0] A_FLIP_X    = 16'(1) << ATTR_FLIP_X_BIT;
    localparam logic [15:0] A_FLIP_Y    = 16'(1) << ATTR_FLIP_Y_BIT;
    localparam logic [15:0] A_REUSE     = 16'(1) << ATTR_REUSE_COLOR_BIT;
    localparam logic [15:0] A_NEXT_SEQ  = 16'(1) << ATTR_NEXT_SEQ_BIT;
    localparam logic [15:0] A_LATCH_Y   = 16'(1) << ATTR_USE_LATCH_Y_BIT;
    localparam logic [15:0] A_INC_Y     = 16'(1) << ATTR_INC_Y_BIT;
    localparam logic [15:0] A_LATCH_X   = 16'(1) << ATTR_USE_LATCH_X_BIT;
    localparam logic [15:0] A_INC_X     = 16'(1) << ATTR_INC_X_BIT;
    localparam logic [15:0] X_EXTRA     = 16'(1) << X_LATCH_EXTRA_BIT;
    localparam logic [15:0] X_MASTER    = 16'(1) << X_LATCH_MASTER_BIT;
    localparam logic [15:0] X_NO_EXTRA  = 16'(1) << X_NO_EXTRA_BIT;
    localparam logic [15:0] X_NO_SCROLL = 16'(1) << X_NO_SCROLL_BIT;
    localparam logic [15:0] Y_CMD       = 16'(1) << Y_IS_CMD_BIT;
    localparam logic [15:0] C_DISABLE   = 16'(1) << CTRL_DISABLE_BIT;
    localparam logic [15:0] C_FLIP      = 16'(1) << CTRL_FLIP_BIT;

    logic        clk;
    logic        reset;
    logic        entry_valid;
    logic        frame_start;
    logic [15:0] tile_word;
    logic [15:0] zoom_word;
    logic [15:0] attr_word;
    logic [15:0] cmd_word;
    logic [15:0] x_word;
    logic [15:0] y_word;
    logic        busy;
    logic        sprite_valid;
    logic [11:0] sprite_x;
    logic [11:0] sprite_y;
    logic [7:0]  sprite_color;
    logic        sprite_flip_x;
    logic        sprite_flip_y;
    logic [15:0] row_valid;
    logic [15:0] col_valid;

    // reference model state
    int master_x;
    int master_y;
    int extra_x;
    int extra_y;
    int base_x;
    int base_y;
    int lat_x;
    int lat_y;
    int lat_color;
    int delta_x;
    int delta_y;
    int row_acc;
    int col_acc;
    int row_count;
    int col_count;
    int row_mask;
    int col_mask;
    bit prev_seq;
    bit ctl_disable;
    bit ctl_flip;
    bit exp_draw;
    bit exp_flip_x;
    bit exp_flip_y;
    int exp_x;
    int exp_y;

    logic [31:0] lfsr_state = 32'he4ef30dd;
    int          cycle_count = 0;

    obj_eval_top obj_eval_top_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run exceeded its cycle limit");
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            fail_run("a value did not match the model");
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        int         i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    // a pixel for every multiple of 256 that the accumulator passes
    task automatic run_zoom(input int delta, inout int acc, output int count, output int mask);
        int sum;
        int i;
        count = 0;
        for (i = 0; i < ZOOM_STEPS; i++) begin
            sum = acc + delta;
            if ((sum / 256) != (acc / 256)) begin
                count++;
            end
            acc = sum % 512;
        end
        mask = (1 << count) - 1;
    endtask

    task automatic predict_entry(input logic [15:0] tile, zoom, attr, cmd, x, y);
        bit seq_start;
        int cx;
        int cy;
        int sx;
        int sy;
        if (y[Y_IS_CMD_BIT]) begin
            ctl_disable = cmd[CTRL_DISABLE_BIT];
            ctl_flip    = cmd[CTRL_FLIP_BIT];
        end
        seq_start = !prev_seq;
        prev_seq  = attr[ATTR_NEXT_SEQ_BIT];
        cx = int'(x[11:0]);
        cy = int'(y[11:0]);
        if (x[X_LATCH_EXTRA_BIT] && !x[X_NO_EXTRA_BIT]) begin
            extra_x = cx;
            extra_y = cy;
        end
        if (x[X_LATCH_MASTER_BIT] && !x[X_NO_SCROLL_BIT]) begin
            master_x = cx;
            master_y = cy;
        end
        sx = 0;
        sy = 0;
        if (!x[X_NO_SCROLL_BIT]) begin
            sx = master_x + (x[X_NO_EXTRA_BIT] ? 0 : extra_x);
            sy = master_y + (x[X_NO_EXTRA_BIT] ? 0 : extra_y);
        end
        if (seq_start) begin
            base_x  = (cx + sx) % 4096;
            base_y  = (cy + sy) % 4096;
            delta_x = 256 - int'(zoom[7:0]);
            delta_y = 256 - int'(zoom[15:8]);
        end
        // position steps use the counts of the entry before
        lat_y = attr[ATTR_USE_LATCH_Y_BIT] ? (lat_y + row_count) % 4096 : base_y;
        if (attr[ATTR_INC_X_BIT]) begin
            lat_x = (lat_x + col_count) % 4096;
        end else if (!attr[ATTR_USE_LATCH_X_BIT]) begin
            lat_x = base_x;
        end
        if (!attr[ATTR_REUSE_COLOR_BIT]) begin
            lat_color = int'(attr[7:0]);
        end
        if (!attr[ATTR_INC_Y_BIT]) begin
            row_acc = 0;
        end
        run_zoom(delta_y, row_acc, row_count, row_mask);
        if (seq_start || attr[ATTR_INC_X_BIT]) begin
            if (!attr[ATTR_INC_X_BIT]) begin
                col_acc = 0;
            end
            run_zoom(delta_x, col_acc, col_count, col_mask);
        end
        exp_draw   = (tile[12:0] != '0) && !ctl_disable && lat_x <= MAX_X && lat_y <= MAX_Y;
        exp_x      = ctl_flip ? FLIP_X_ORIGIN - lat_x : lat_x;
        exp_y      = ctl_flip ? FLIP_Y_ORIGIN - lat_y : lat_y;
        exp_flip_x = attr[ATTR_FLIP_X_BIT] ^ ctl_flip;
        exp_flip_y = attr[ATTR_FLIP_Y_BIT] ^ ctl_flip;
    endtask

    task automatic run_entry(input logic [15:0] tile, zoom, attr, cmd, x, y);
        int cycles;
        int early;
        predict_entry(tile, zoom, attr, cmd, x, y);
        @(posedge clk);
        #1;
        check_value("busy before entry", 32'(busy), 32'd0);
        tile_word   = tile;
        zoom_word   = zoom;
        attr_word   = attr;
        cmd_word    = cmd;
        x_word      = x;
        y_word      = y;
        entry_valid = 1'b1;
        @(posedge clk);
        #1;
        entry_valid = 1'b0;
        cycles = 0;
        early  = 0;
        do begin
            @(negedge clk);
            if (busy) begin
                cycles++;
                early += int'(sprite_valid);
            end
            if (cycles > ENTRY_CYCLES) begin
                fail_run("busy stayed high past the per-entry cycle limit");
            end
        end while (busy);
        check_value("busy cycles", 32'(cycles), 32'(ENTRY_LATENCY));
        check_value("early sprite_valid", 32'(early), 32'd0);
        check_value("sprite_valid", 32'(sprite_valid), 32'(exp_draw));
        check_value("assertion failures", 32'(obj_eval_top_i.eval_checks.failures), 32'd0);
        if (exp_draw) begin
            check_value("sprite_x", 32'(sprite_x), 32'(exp_x));
            check_value("sprite_y", 32'(sprite_y), 32'(exp_y));
            check_value("sprite_color", 32'(sprite_color), 32'(lat_color));
            check_value("sprite_flip_x", 32'(sprite_flip_x), 32'(exp_flip_x));
            check_value("sprite_flip_y", 32'(sprite_flip_y), 32'(exp_flip_y));
            check_value("row_valid", 32'(row_valid), 32'(row_mask));
            check_value("col_valid", 32'(col_valid), 32'(col_mask));
        end
    endtask

    task automatic pulse_frame_start();
        @(posedge clk);
        #1;
        frame_start = 1'b1;
        @(posedge clk);
        #1;
        frame_start = 1'b0;
        extra_x = 0;
        extra_y = 0;
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        entry_valid = 1'b0;
        frame_start = 1'b0;
        tile_word   = '0;
        zoom_word   = '0;
        attr_word   = '0;
        cmd_word    = '0;
        x_word      = '0;
        y_word      = '0;
        {master_x, master_y, extra_x, extra_y, base_x, base_y} = '0;
        {lat_x, lat_y, lat_color, row_acc, col_acc} = '0;
        {row_count, col_count, row_mask, col_mask} = '0;
        {prev_seq, ctl_disable, ctl_flip} = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic single_sprite();
        run_entry(16'h0123, 16'h0000, 16'h0045, 16'h0000, X_NO_SCROLL | 16'd100, 16'd50);
        check_value("row_valid", 32'(row_valid), 32'h0000ffff);
        check_value("col_valid", 32'(col_valid), 32'h0000ffff);
    endtask

    task automatic scroll_latching();
        run_entry(16'h0010, 16'h0000, 16'h0001, 16'h0000, X_MASTER | 16'd20, 16'd10);
        run_entry(16'h0011, 16'h0000, 16'h0002, 16'h0000, X_EXTRA | 16'd5, 16'd3);
        // latch request is ignored when extra scroll is off
        run_entry(16'h0015, 16'h0000, 16'h0006, 16'h0000, X_NO_EXTRA | X_EXTRA | 16'd77, 16'd7);
        run_entry(16'h0012, 16'h0000, 16'h0003, 16'h0000, 16'd100, 16'd50);
        run_entry(16'h0013, 16'h0000, 16'h0004, 16'h0000, X_NO_EXTRA | 16'd100, 16'd50);
        run_entry(16'h0014, 16'h0000, 16'h0005, 16'h0000, X_NO_SCROLL | 16'd100, 16'd50);
        pulse_frame_start();
        run_entry(16'h0016, 16'h0000, 16'h0007, 16'h0000, 16'd100, 16'd50);
    endtask

    task automatic zoom_sequence();
        logic [15:0] zoom;
        logic [15:0] step;
        int          round;
        step = A_INC_X | A_INC_Y | A_LATCH_Y;
        for (round = 0; round < 4; round++) begin
            zoom = {random_byte(), random_byte()};
            run_entry(16'h0100, zoom, A_NEXT_SEQ | 16'h0030, 16'h0000,
                      X_NO_SCROLL | 16'd200, 16'd100);
            run_entry(16'h0101, 16'h0000, A_NEXT_SEQ | step | 16'h0031, 16'h0000,
                      X_NO_SCROLL | 16'd200, 16'd100);
            run_entry(16'h0102, 16'h0000, step | 16'h0032, 16'h0000,
                      X_NO_SCROLL | 16'd200, 16'd100);
        end
    endtask

    task automatic command_entries();
        run_entry(16'h0200, 16'h0000, A_FLIP_X | 16'h0040, C_FLIP,
                  X_NO_SCROLL | 16'd100, Y_CMD | 16'd60);
        run_entry(16'h0201, 16'h0000, A_FLIP_Y | 16'h0041, 16'h0000,
                  X_NO_SCROLL | 16'd30, 16'd20);
        run_entry(16'h0202, 16'h0000, 16'h0042, C_DISABLE | C_FLIP,
                  X_NO_SCROLL | 16'd30, Y_CMD | 16'd20);
        run_entry(16'h0203, 16'h0000, 16'h0043, 16'h0000, X_NO_SCROLL | 16'd30, 16'd20);
        run_entry(16'h0204, 16'h0000, 16'h0044, 16'h0000, X_NO_SCROLL | 16'd30, Y_CMD | 16'd20);
        // cmd_word alone does nothing without the command flag in y
        run_entry(16'h0205, 16'h0000, 16'h0045, C_DISABLE, X_NO_SCROLL | 16'd30, 16'd20);
    endtask

    task automatic drop_cases();
        run_entry(16'h2000, 16'h0000, 16'h0050, 16'h0000, X_NO_SCROLL | 16'd40, 16'd40);
        run_entry(16'h0400, 16'h0000, 16'h0051, 16'h0000, X_NO_SCROLL | 16'd481, 16'd40);
        run_entry(16'h0401, 16'h0000, 16'h0052, 16'h0000, X_NO_SCROLL | 16'd480, 16'd40);
        run_entry(16'h0402, 16'h0000, 16'h0053, 16'h0000, X_NO_SCROLL | 16'd40, 16'd241);
        run_entry(16'h0403, 16'h0000, 16'h0054, 16'h0000, X_NO_SCROLL | 16'd40, 16'd240);
    endtask

    task automatic colour_and_latch_paths();
        run_entry(16'h0300, 16'h2020, A_NEXT_SEQ | 16'h0011, 16'h0000,
                  X_NO_SCROLL | 16'd50, 16'd40);
        // x steps away from the base so that holding the latch is visible
        run_entry(16'h0301, 16'h0000, A_NEXT_SEQ | A_REUSE | A_INC_X | 16'h0022, 16'h0000,
                  X_NO_SCROLL | 16'd90, 16'd90);
        run_entry(16'h0302, 16'h0000, A_REUSE | A_LATCH_X | A_LATCH_Y | 16'h0033, 16'h0000,
                  X_NO_SCROLL | 16'd90, 16'd90);
        run_entry(16'h0303, 16'h0000, 16'h0044, 16'h0000, X_NO_SCROLL | 16'd60, 16'd70);
    endtask

    initial begin
        apply_reset();
        single_sprite();
        scroll_latching();
        zoom_sequence();
        command_entries();
        drop_cases();
        colour_and_latch_paths();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tests/obj_eval_assert.sv
module obj_eval_assert (
    input logic clk,
    input logic reset,
    input logic accept,
    input logic busy,
    input logic sprite_valid
);

    int unsigned failures = 0;

    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        sprite_valid |=> !sprite_valid)
        else begin
            $error("sprite_valid held longer than one cycle");
            failures++;
        end

    // the result strobe comes with the end of busy
    strobe_at_busy_fall: assert property (@(posedge clk) disable iff (reset)
        sprite_valid |-> $fell(busy))
        else begin
            $error("sprite_valid outside the busy falling edge");
            failures++;
        end

    busy_falls_on_time: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##21 $fell(busy))
        else begin
            $error("busy did not fall 20 cycles after accept");
            failures++;
        end

    busy_not_early: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(accept, 21))
        else begin
            $error("busy fell without an accept 20 cycles before");
            failures++;
        end

endmodule

bind obj_eval_top obj_eval_assert eval_checks (
    .clk,
    .reset,
    .accept(entry_valid && !busy),
    .busy,
    .sprite_valid
);

// File: rtl/obj_eval_top.sv
module obj_eval_top
    import obj_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  entry_valid,
    input  logic [WORD_W-1:0]     tile_word,
    input  logic [WORD_W-1:0]     zoom_word,
    input  logic [WORD_W-1:0]     attr_word,
    input  logic [WORD_W-1:0]     cmd_word,
    input  logic [WORD_W-1:0]     x_word,
    input  logic [WORD_W-1:0]     y_word,
    input  logic                  frame_start,
    output logic                  busy,
    output logic                  sprite_valid,
    output logic [COORD_W-1:0]    sprite_x,
    output logic [COORD_W-1:0]    sprite_y,
    output logic [COLOR_W-1:0]    sprite_color,
    output logic                  sprite_flip_x,
    output logic                  sprite_flip_y,
    output logic [ZOOM_STEPS-1:0] row_valid,
    output logic [ZOOM_STEPS-1:0] col_valid
);

    logic                  eval_seq;
    logic                  eval_pos;
    logic                  place;
    logic                  seq_start;
    logic                  ctrl_disable;
    logic                  ctrl_flip;
    logic                  start_row;
    logic                  start_col;
    logic                  cont_row;
    logic                  cont_col;
    logic                  ready_row;
    logic                  ready_col;
    logic [WORD_W-1:0]     held_tile;
    logic [WORD_W-1:0]     held_zoom;
    logic [WORD_W-1:0]     held_attr;
    logic [WORD_W-1:0]     held_x;
    logic [WORD_W-1:0]     held_y;
    logic [COORD_W-1:0]    latched_x;
    logic [COORD_W-1:0]    latched_y;
    logic [COLOR_W-1:0]    latched_color;
    logic [ZOOM_W-1:0]     delta_x;
    logic [ZOOM_W-1:0]     delta_y;
    logic [COUNT_W-1:0]    row_count;
    logic [COUNT_W-1:0]    col_count;
    logic [ZOOM_STEPS-1:0] row_mask;
    logic [ZOOM_STEPS-1:0] col_mask;

    obj_entry_sequencer sequencer (
        .clk, .reset, .entry_valid,
        .tile_word, .zoom_word, .attr_word, .cmd_word, .x_word, .y_word,
        // an idle column calculator keeps ready high
        .zoom_ready(ready_row && ready_col),
        .busy, .eval_seq, .eval_pos,
        .zoom_start_row(start_row), .zoom_start_col(start_col),
        .zoom_cont_row(cont_row), .zoom_cont_col(cont_col),
        .place, .seq_start, .ctrl_disable, .ctrl_flip,
        .held_tile, .held_zoom, .held_attr, .held_x, .held_y
    );

    obj_scroll_latch scroll_latch (
        .clk, .reset,
        .frame_start(frame_start && !busy),
        .eval_seq, .eval_pos, .seq_start,
        .x_word(held_x), .y_word(held_y), .attr_word(held_attr), .zoom_word(held_zoom),
        .row_count, .col_count,
        .latched_x, .latched_y, .latched_color, .delta_x, .delta_y
    );

    obj_zoom_calc row_zoom (
        .clk, .reset, .start(start_row), .cont(cont_row), .delta(delta_y),
        .ready(ready_row), .count(row_count), .valid(row_mask)
    );

    obj_zoom_calc col_zoom (
        .clk, .reset, .start(start_col), .cont(cont_col), .delta(delta_x),
        .ready(ready_col), .count(col_count), .valid(col_mask)
    );

    obj_placement placement (
        .clk, .reset, .place,
        .tile_word(held_tile), .attr_word(held_attr),
        .ctrl_disable, .ctrl_flip, .latched_x, .latched_y, .latched_color,
        .row_mask, .col_mask,
        .sprite_valid, .sprite_x, .sprite_y, .sprite_color,
        .sprite_flip_x, .sprite_flip_y, .row_valid, .col_valid
    );

endmodule

// File: rtl/obj_placement.sv
module obj_placement
    import obj_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  place,
    input  logic [WORD_W-1:0]     tile_word,
    input  logic [WORD_W-1:0]     attr_word,
    input  logic                  ctrl_disable,
    input  logic                  ctrl_flip,
    input  logic [COORD_W-1:0]    latched_x,
    input  logic [COORD_W-1:0]    latched_y,
    input  logic [COLOR_W-1:0]    latched_color,
    input  logic [ZOOM_STEPS-1:0] row_mask,
    input  logic [ZOOM_STEPS-1:0] col_mask,
    output logic                  sprite_valid,
    output logic [COORD_W-1:0]    sprite_x,
    output logic [COORD_W-1:0]    sprite_y,
    output logic [COLOR_W-1:0]    sprite_color,
    output logic                  sprite_flip_x,
    output logic                  sprite_flip_y,
    output logic [ZOOM_STEPS-1:0] row_valid,
    output logic [ZOOM_STEPS-1:0] col_valid
);

    logic drop;
    logic draw;

    // bounds are checked before the flip-screen transform
    assign drop = (tile_word[TILE_CODE_W-1:0] == '0)
                || ctrl_disable
                || (latched_x > COORD_W'(MAX_X))
                || (latched_y > COORD_W'(MAX_Y));
    assign draw = place && !drop;

    always_ff @(posedge clk) begin
        if (reset) begin
            sprite_valid <= 1'b0;
        end else begin
            sprite_valid <= draw;
        end
    end

    always_ff @(posedge clk) begin
        if (draw) begin
            sprite_x      <= ctrl_flip ? COORD_W'(FLIP_X_ORIGIN) - latched_x : latched_x;
            sprite_y      <= ctrl_flip ? COORD_W'(FLIP_Y_ORIGIN) - latched_y : latched_y;
            sprite_flip_x <= attr_word[ATTR_FLIP_X_BIT] ^ ctrl_flip;
            sprite_flip_y <= attr_word[ATTR_FLIP_Y_BIT] ^ ctrl_flip;
            sprite_color  <= latched_color;
            row_valid     <= row_mask;
            col_valid     <= col_mask;
        end
    end

endmodule

// File: rtl/obj_scroll_latch.sv
module obj_scroll_latch
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_start,
    input  logic               eval_seq,
    input  logic               eval_pos,
    input  logic               seq_start,
    input  logic [WORD_W-1:0]  x_word,
    input  logic [WORD_W-1:0]  y_word,
    input  logic [WORD_W-1:0]  attr_word,
    input  logic [WORD_W-1:0]  zoom_word,
    input  logic [COUNT_W-1:0] row_count,
    input  logic [COUNT_W-1:0] col_count,
    output logic [COORD_W-1:0] latched_x,
    output logic [COORD_W-1:0] latched_y,
    output logic [COLOR_W-1:0] latched_color,
    output logic [ZOOM_W-1:0]  delta_x,
    output logic [ZOOM_W-1:0]  delta_y
);

    logic [COORD_W-1:0] master_x;
    logic [COORD_W-1:0] master_y;
    logic [COORD_W-1:0] extra_x;
    logic [COORD_W-1:0] extra_y;
    logic [COORD_W-1:0] base_x;
    logic [COORD_W-1:0] base_y;
    logic [COORD_W-1:0] coord_x;
    logic [COORD_W-1:0] coord_y;
    logic [COORD_W-1:0] scroll_x;
    logic [COORD_W-1:0] scroll_y;
    logic [COORD_W-1:0] base_x_next;
    logic [COORD_W-1:0] base_y_next;
    logic               no_extra;
    logic               no_scroll;

    assign coord_x   = x_word[COORD_W-1:0];
    assign coord_y   = y_word[COORD_W-1:0];
    assign no_extra  = x_word[X_NO_EXTRA_BIT];
    assign no_scroll = x_word[X_NO_SCROLL_BIT];

    // scroll flags of the x word apply to both axes
    assign scroll_x = no_scroll ? '0 : master_x + (no_extra ? '0 : extra_x);
    assign scroll_y = no_scroll ? '0 : master_y + (no_extra ? '0 : extra_y);

    // base only moves at the head of a sequence
    assign base_x_next = seq_start ? coord_x + scroll_x : base_x;
    assign base_y_next = seq_start ? coord_y + scroll_y : base_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            master_x      <= '0;
            master_y      <= '0;
            extra_x       <= '0;
            extra_y       <= '0;
            latched_x     <= '0;
            latched_y     <= '0;
            latched_color <= '0;
        end else begin
            if (frame_start) begin
                extra_x <= '0;
                extra_y <= '0;
            end
            if (eval_seq) begin
                if (x_word[X_LATCH_EXTRA_BIT] && !no_extra) begin
                    extra_x <= coord_x;
                    extra_y <= coord_y;
                end
                if (x_word[X_LATCH_MASTER_BIT] && !no_scroll) begin
                    master_x <= coord_x;
                    master_y <= coord_y;
                end
            end
            if (eval_pos) begin
                // counts still hold what the previous entry produced
                if (attr_word[ATTR_USE_LATCH_Y_BIT]) begin
                    latched_y <= latched_y + COORD_W'(row_count);
                end else begin
                    latched_y <= base_y_next;
                end
                if (attr_word[ATTR_INC_X_BIT]) begin
                    latched_x <= latched_x + COORD_W'(col_count);
                end else if (!attr_word[ATTR_USE_LATCH_X_BIT]) begin
                    latched_x <= base_x_next;
                end
                if (!attr_word[ATTR_REUSE_COLOR_BIT]) begin
                    latched_color <= attr_word[COLOR_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (eval_pos && seq_start) begin
            base_x  <= base_x_next;
            base_y  <= base_y_next;
            // low zoom byte is x, high byte is y
            delta_x <= ZOOM_W'(ZOOM_UNITY) - ZOOM_W'(zoom_word[7:0]);
            delta_y <= ZOOM_W'(ZOOM_UNITY) - ZOOM_W'(zoom_word[15:8]);
        end
    end

endmodule

// File: rtl/obj_entry_sequencer.sv
module obj_entry_sequencer
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              entry_valid,
    input  logic [WORD_W-1:0] tile_word,
    input  logic [WORD_W-1:0] zoom_word,
    input  logic [WORD_W-1:0] attr_word,
    input  logic [WORD_W-1:0] cmd_word,
    input  logic [WORD_W-1:0] x_word,
    input  logic [WORD_W-1:0] y_word,
    input  logic              zoom_ready,
    output logic              busy,
    output logic              eval_seq,
    output logic              eval_pos,
    output logic              zoom_start_row,
    output logic              zoom_start_col,
    output logic              zoom_cont_row,
    output logic              zoom_cont_col,
    output logic              place,
    output logic              seq_start,
    output logic              ctrl_disable,
    output logic              ctrl_flip,
    output logic [WORD_W-1:0] held_tile,
    output logic [WORD_W-1:0] held_zoom,
    output logic [WORD_W-1:0] held_attr,
    output logic [WORD_W-1:0] held_x,
    output logic [WORD_W-1:0] held_y
);

    eval_state_t state;
    logic        prev_seq;
    logic        accept;

    assign accept = (state == IDLE) && entry_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            busy         <= 1'b0;
            prev_seq     <= 1'b0;
            seq_start    <= 1'b0;
            ctrl_disable <= 1'b0;
            ctrl_flip    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (entry_valid) begin
                        busy  <= 1'b1;
                        state <= EVAL_SEQ;
                        // command word takes effect for this very entry
                        if (y_word[Y_IS_CMD_BIT]) begin
                            ctrl_disable <= cmd_word[CTRL_DISABLE_BIT];
                            ctrl_flip    <= cmd_word[CTRL_FLIP_BIT];
                        end
                    end
                end
                EVAL_SEQ: begin
                    seq_start <= ~prev_seq;
                    prev_seq  <= held_attr[ATTR_NEXT_SEQ_BIT];
                    state     <= EVAL_POS;
                end
                EVAL_POS: begin
                    state <= EVAL_ZOOM;
                end
                EVAL_ZOOM: begin
                    state <= ZOOM_WAIT;
                end
                ZOOM_WAIT: begin
                    if (zoom_ready) begin
                        state <= PLACE;
                    end
                end
                PLACE: begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    // entry words are only valid during the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            held_tile <= tile_word;
            held_zoom <= zoom_word;
            held_attr <= attr_word;
            held_x    <= x_word;
            held_y    <= y_word;
        end
    end

    assign eval_seq = (state == EVAL_SEQ);
    assign eval_pos = (state == EVAL_POS);
    assign place    = (state == PLACE);

    // row stepping always runs, columns only restart on a new sequence or x step
    assign zoom_start_row = (state == EVAL_ZOOM);
    assign zoom_start_col = (state == EVAL_ZOOM) && (seq_start || held_attr[ATTR_INC_X_BIT]);
    assign zoom_cont_row  = held_attr[ATTR_INC_Y_BIT];
    assign zoom_cont_col  = held_attr[ATTR_INC_X_BIT];

endmodule

// File: rtl/obj_zoom_calc.sv
module obj_zoom_calc
    import obj_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  cont,
    input  logic [ZOOM_W-1:0]     delta,
    output logic                  ready,
    output logic [COUNT_W-1:0]    count,
    output logic [ZOOM_STEPS-1:0] valid
);

    logic [ZOOM_W-1:0] accum;
    logic [STEP_W-1:0] index;
    logic [ZOOM_W-1:0] sum_in;
    logic [ZOOM_W-1:0] sum_out;
    logic              carry;

    // the start cycle already performs the first step
    assign sum_in  = start ? (cont ? accum : '0) : accum;
    assign sum_out = sum_in + delta;
    // a pixel is emitted whenever the top bit toggles
    assign carry   = sum_out[ZOOM_W-1] ^ sum_in[ZOOM_W-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b1;
            accum <= '0;
            index <= '0;
            count <= '0;
            valid <= '0;
        end else if (start) begin
            ready <= 1'b0;
            accum <= sum_out;
            index <= STEP_W'(1);
            count <= COUNT_W'(carry);
            valid <= ZOOM_STEPS'(carry);
        end else if (!ready) begin
            accum <= sum_out;
            index <= index + 1'b1;
            if (carry) begin
                valid[count[STEP_W-1:0]] <= 1'b1;
                count <= count + 1'b1;
            end
            if (index == STEP_W'(ZOOM_STEPS - 1)) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

// File: common/obj_pkg.sv
package obj_pkg;

    // entry word and field widths
    localparam int WORD_W      = 16;
    localparam int COORD_W     = 12;
    localparam int COLOR_W     = 8;
    localparam int TILE_CODE_W = 13;

    // zoom stepping
    localparam int ZOOM_W     = 9;
    localparam int ZOOM_UNITY = 256;
    localparam int ZOOM_STEPS = 16;
    localparam int STEP_W     = 4;
    localparam int COUNT_W    = 5;

    // x word flags, coordinate sits in the low bits
    localparam int X_LATCH_EXTRA_BIT  = 12;
    localparam int X_LATCH_MASTER_BIT = 13;
    localparam int X_NO_EXTRA_BIT     = 14;
    localparam int X_NO_SCROLL_BIT    = 15;

    // attribute word, colour sits in the low byte
    localparam int ATTR_FLIP_X_BIT       = 8;
    localparam int ATTR_FLIP_Y_BIT       = 9;
    localparam int ATTR_REUSE_COLOR_BIT  = 10;
    localparam int ATTR_NEXT_SEQ_BIT     = 11;
    localparam int ATTR_USE_LATCH_Y_BIT  = 12;
    localparam int ATTR_INC_Y_BIT        = 13;
    localparam int ATTR_USE_LATCH_X_BIT  = 14;
    localparam int ATTR_INC_X_BIT        = 15;

    // y word marks a command entry
    localparam int Y_IS_CMD_BIT = 15;

    // command word bits kept in the control register
    localparam int CTRL_DISABLE_BIT = 12;
    localparam int CTRL_FLIP_BIT    = 13;

    // flip-screen origins and visible limits
    localparam int FLIP_X_ORIGIN = 496;
    localparam int FLIP_Y_ORIGIN = 240;
    localparam int MAX_X         = 480;
    localparam int MAX_Y         = 240;

    typedef enum logic [2:0] {
        IDLE,
        EVAL_SEQ,
        EVAL_POS,
        EVAL_ZOOM,
        ZOOM_WAIT,
        PLACE
    } eval_state_t;

endpackage
